// File: vlog.f
isaPkg.sv
busPkg.sv
instrDecoder.sv
execUnit.sv
resultBank.sv
wbSlavePort.sv
decodeCore.sv
decodeCore_assert.sv
tbChecker.sv
tbDecodeCore.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbDecodeCore
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --timing --assert
SIMARGS   ?= +verilator+error+limit+100
PASSTEXT  ?= Simulation passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSTEXT)"

clean:
	rm -rf $(OBJDIR)

// File: tbDecodeCore.sv
`timescale 1ns/100ps

module tbDecodeCore;
    import isaPkg::*;
    import busPkg::*;

    localparam int ClkPeriod   = 8;
    localparam int ResetCycles = 8;
    localparam int NumTests    = 43;
    localparam int MaxPolls    = 10;
    localparam int WatchdogNs  = NumTests * 40 * ClkPeriod + ResetCycles * ClkPeriod;

    localparam logic [31:0] Pc  = 32'h0040_0100;
    localparam logic [31:0] Pc4 = 32'h0040_0104;
    localparam logic [31:0] Pc8 = 32'h0040_0108;

    typedef struct packed {
        logic [8*12-1:0] name;
        logic [31:0]     rs;
        logic [31:0]     rt;
        logic [31:0]     pc;
        logic [31:0]     instr;
        logic [31:0]     expResult;
        logic [31:0]     expDest;
        logic [31:0]     expNextPc;
    } testT;

    logic                   clk;
    logic                   arstN;
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [WbAddrWidth-1:0] adr;
    logic [WbDataWidth-1:0] datW;
    logic [WbDataWidth-1:0] datR;
    logic                   ack;

    logic                   checkEn;
    logic [8*12-1:0]        expName;
    logic [31:0]            expValue;
    logic [31:0]            expMask;
    logic                   pollFailed;
    int                     mismatchCount;
    int                     pollFailCount;

    testT                   tests [NumTests];
    int                     testCount;

    decodeCore UUT (
        .clk  (clk),
        .arstN(arstN),
        .cyc  (cyc),
        .stb  (stb),
        .we   (we),
        .adr  (adr),
        .datW (datW),
        .datR (datR),
        .ack  (ack)
    );

    tbChecker uChecker (
        .clk          (clk),
        .ack          (ack),
        .we           (we),
        .adr          (adr),
        .datR         (datR),
        .checkEn      (checkEn),
        .testName     (expName),
        .expValue     (expValue),
        .expMask      (expMask),
        .pollFailed   (pollFailed),
        .mismatchCount(mismatchCount),
        .pollFailCount(pollFailCount)
    );

    always #(ClkPeriod/2) clk = ~clk;

    //////////////////////////////////////////////////
    // instruction encoding
    function automatic logic [31:0] encR(input int rs, rt, rd, sh, input logic [5:0] fn);
        return {6'b000000, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
    endfunction

    function automatic logic [31:0] encI(input logic [5:0] op, input int rs, rt,
                                         input logic [15:0] imm);
        return {op, rs[4:0], rt[4:0], imm};
    endfunction

    function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] idx);
        return {op, idx};
    endfunction

    //////////////////////////////////////////////////
    // Wishbone host tasks called just after a rising edge
    task automatic busWrite(input logic [WbAddrWidth-1:0] addr, input logic [31:0] data);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = 1'b1;
        adr  = addr;
        datW = data;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        cyc = 1'b0;
        stb = 1'b0;
        // slave rearms only after stb has been seen low
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic busRead(input logic [WbAddrWidth-1:0] addr, output logic [31:0] data);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = addr;
        do begin
            @(posedge clk);
            #1;
        end while (!ack);
        data = datR;
        cyc  = 1'b0;
        stb  = 1'b0;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic checkRead(input logic [WbAddrWidth-1:0] addr, input logic [31:0] value,
                             input logic [31:0] mask);
        logic [31:0] data;
        expValue = value;
        expMask  = mask;
        checkEn  = 1'b1;
        busRead(addr, data);
        checkEn  = 1'b0;
    endtask

    task automatic addTest(input logic [8*12-1:0] name, input logic [31:0] rs, rt, pc, instr,
                           input logic [31:0] res, dest, npc);
        tests[testCount] = '{name, rs, rt, pc, instr, res, dest, npc};
        testCount++;
    endtask

    //////////////////////////////////////////////////
    // stimulus table with hand-computed results
    task automatic loadTests();
        testCount = 0;
        addTest("addu", 32'h7fff_fff0, 32'h0000_0020, Pc, encR(1, 2, 3, 0, fnAddu),
                32'h8000_0010, 32'h103, Pc4);
        addTest("sub", 32'h0000_0005, 32'hffff_fffd, Pc, encR(1, 2, 3, 0, fnSub),
                32'h0000_0008, 32'h103, Pc4);
        addTest("and", 32'hf0f0_1234, 32'h0ff0_ff00, Pc, encR(1, 2, 3, 0, fnAnd),
                32'h00f0_1200, 32'h103, Pc4);
        addTest("or", 32'hf000_000f, 32'h0f00_00f0, Pc, encR(1, 2, 3, 0, fnOr),
                32'hff00_00ff, 32'h103, Pc4);
        addTest("nor", 32'h0000_ff00, 32'h00ff_0000, Pc, encR(1, 2, 3, 0, fnNor),
                32'hff00_00ff, 32'h103, Pc4);
        addTest("xor", 32'haaaa_5555, 32'hffff_0000, Pc, encR(1, 2, 3, 0, fnXor),
                32'h5555_5555, 32'h103, Pc4);
        addTest("slt", 32'hffff_fff0, 32'h0000_0001, Pc, encR(1, 2, 3, 0, fnSlt),
                32'h0000_0001, 32'h103, Pc4);
        addTest("sltu", 32'hffff_fff0, 32'h0000_0001, Pc, encR(1, 2, 3, 0, fnSltu),
                32'h0000_0000, 32'h103, Pc4);
        // shifts act on the rt value
        addTest("sll", 32'h0000_0003, 32'h0000_00ff, Pc, encR(0, 2, 3, 4, fnSll),
                32'h0000_0ff0, 32'h103, Pc4);
        addTest("srl", 32'h0000_0000, 32'h8000_0000, Pc, encR(0, 2, 3, 31, fnSrl),
                32'h0000_0001, 32'h103, Pc4);
        addTest("sra", 32'h0000_0000, 32'h8000_0010, Pc, encR(0, 2, 3, 4, fnSra),
                32'hf800_0001, 32'h103, Pc4);
        addTest("sllv", 32'h0000_0024, 32'h0000_0001, Pc, encR(1, 2, 3, 0, fnSllv),
                32'h0000_0010, 32'h103, Pc4);
        addTest("srlv", 32'h0000_0008, 32'hff00_0000, Pc, encR(1, 2, 3, 0, fnSrlv),
                32'h00ff_0000, 32'h103, Pc4);
        addTest("srav", 32'h0000_0010, 32'h8765_4321, Pc, encR(1, 2, 3, 0, fnSrav),
                32'hffff_8765, 32'h103, Pc4);
        addTest("nop", 32'h0000_1234, 32'h0000_0000, Pc, 32'h0000_0000,
                32'h0000_0000, 32'h100, Pc4);
        // immediate group writes rt
        addTest("ori", 32'h1234_0000, 32'h0, Pc, encI(opOri, 1, 2, 16'h8001),
                32'h1234_8001, 32'h102, Pc4);
        addTest("andi", 32'hffff_ffff, 32'h0, Pc, encI(opAndi, 1, 2, 16'h8f0f),
                32'h0000_8f0f, 32'h102, Pc4);
        addTest("xori", 32'h0000_ffff, 32'h0, Pc, encI(opXori, 1, 2, 16'hff00),
                32'h0000_00ff, 32'h102, Pc4);
        addTest("addiu", 32'h0000_0010, 32'h0, Pc, encI(opAddiu, 1, 2, 16'hfff0),
                32'h0000_0000, 32'h102, Pc4);
        addTest("addi", 32'h0000_0100, 32'h0, Pc, encI(opAddi, 1, 2, 16'h8000),
                32'hffff_8100, 32'h102, Pc4);
        addTest("slti", 32'hffff_fffe, 32'h0, Pc, encI(opSlti, 1, 2, 16'hffff),
                32'h0000_0001, 32'h102, Pc4);
        addTest("sltiu", 32'h0000_0005, 32'h0, Pc, encI(opSltiu, 1, 2, 16'hffff),
                32'h0000_0001, 32'h102, Pc4);
        addTest("lui", 32'hdead_beef, 32'h0, Pc, encI(opLui, 0, 2, 16'h1234),
                32'h1234_0000, 32'h102, Pc4);
        // branch target is PC+4 plus offset times four
        addTest("beq taken", 32'h7, 32'h7, Pc, encI(opBeq, 1, 2, 16'h0010),
                32'h0, 32'h200, 32'h0040_0144);
        addTest("beq fall", 32'h7, 32'h8, Pc, encI(opBeq, 1, 2, 16'h0010),
                32'h0, 32'h000, Pc4);
        addTest("bne taken", 32'h1, 32'h2, Pc, encI(opBne, 1, 2, 16'hfff8),
                32'h0, 32'h200, 32'h0040_00e4);
        addTest("bne fall", 32'h3, 32'h3, Pc, encI(opBne, 1, 2, 16'hfff8),
                32'h0, 32'h000, Pc4);
        addTest("bgtz taken", 32'h1, 32'h0, Pc, encI(opBgtz, 1, 0, 16'h0002),
                32'h0, 32'h200, 32'h0040_010c);
        addTest("bgtz fall", 32'h0, 32'h0, Pc, encI(opBgtz, 1, 0, 16'h0002),
                32'h0, 32'h000, Pc4);
        addTest("blez taken", 32'h0, 32'h0, Pc, encI(opBlez, 1, 0, 16'h0003),
                32'h0, 32'h200, 32'h0040_0110);
        addTest("blez fall", 32'h5, 32'h0, Pc, encI(opBlez, 1, 0, 16'h0003),
                32'h0, 32'h000, Pc4);
        addTest("bgez taken", 32'h0, 32'h0, Pc, encI(opRegImm, 1, 1, 16'h0001),
                32'h0, 32'h200, 32'h0040_0108);
        addTest("bgez fall", 32'h8000_0000, 32'h0, Pc, encI(opRegImm, 1, 1, 16'h0001),
                32'h0, 32'h000, Pc4);
        addTest("bltz taken", 32'hffff_ffff, 32'h0, Pc, encI(opRegImm, 1, 0, 16'hffff),
                32'h0, 32'h200, 32'h0040_0100);
        addTest("bltz fall", 32'h1, 32'h0, Pc, encI(opRegImm, 1, 0, 16'hffff),
                32'h0, 32'h000, Pc4);
        // jumps
        addTest("j", 32'h0, 32'h0, 32'h1040_0100, encJ(opJ, 26'h000_0040),
                32'h0, 32'h000, 32'h1000_0100);
        addTest("jal", 32'h0, 32'h0, Pc, encJ(opJal, 26'h010_0100),
                Pc8, 32'h11f, 32'h0040_0400);
        addTest("jr", 32'h0040_1000, 32'h0, Pc, encR(1, 0, 0, 0, fnJr),
                32'h0, 32'h000, 32'h0040_1000);
        addTest("jalr", 32'h0040_2000, 32'h0, Pc, encR(1, 0, 5, 0, fnJalr),
                Pc8, 32'h105, 32'h0040_2000);
        // dropped and unknown encodings
        addTest("mult", 32'h3, 32'h4, Pc, encR(1, 2, 0, 0, 6'h18),
                32'h0, 32'h400, Pc4);
        addTest("lw", 32'h3, 32'h4, Pc, encI(6'h23, 1, 2, 16'h0010),
                32'h0, 32'h400, Pc4);
        addTest("sw", 32'h3, 32'h4, Pc, encI(6'h2b, 1, 2, 16'h0010),
                32'h0, 32'h400, Pc4);
        addTest("unknown op", 32'h3, 32'h4, Pc, encI(6'h3f, 1, 2, 16'h0000),
                32'h0, 32'h400, Pc4);
    endtask

    //////////////////////////////////////////////////
    // one table entry
    task automatic runTest(input testT t);
        logic [31:0] status;
        logic [31:0] unchecked;
        int          polls;
        logic        writes;
        busWrite(AddrRs, t.rs);
        busWrite(AddrRt, t.rt);
        busWrite(AddrPc, t.pc);
        busWrite(AddrInstr, t.instr);
        expName = t.name;
        status  = '0;
        polls   = 0;
        while (!status[0] && polls < MaxPolls) begin
            busRead(AddrStatus, status);
            polls++;
        end
        if (!status[0]) begin
            pollFailed = 1'b1;
            @(posedge clk);
            #1;
            pollFailed = 1'b0;
        end else begin
            writes = t.expDest[DestWriteBit];
            // write-back value only defined with a register write
            if (writes) begin
                checkRead(AddrResult, t.expResult, 32'hffff_ffff);
            end else begin
                busRead(AddrResult, unchecked);
            end
            // dest index only defined with a register write
            checkRead(AddrDest, t.expDest, writes ? 32'hffff_ffff : 32'hffff_ff00);
            checkRead(AddrNextPc, t.expNextPc, 32'hffff_ffff);
        end
    endtask

    initial begin
        int assertFails;
        clk        = 1'b0;
        arstN      = 1'b0;
        cyc        = 1'b0;
        stb        = 1'b0;
        we         = 1'b0;
        adr        = '0;
        datW       = '0;
        checkEn    = 1'b0;
        expName    = '0;
        expValue   = '0;
        expMask    = '0;
        pollFailed = 1'b0;
        loadTests();
        repeat (ResetCycles) @(posedge clk);
        #1;
        arstN = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < testCount; i++) begin
            runTest(tests[i]);
        end
        repeat (4) @(posedge clk);
        assertFails = UUT.uAssert.failCount;
        $display("Totals: %0d mismatches, %0d poll timeouts, %0d assertion failures",
                 mismatchCount, pollFailCount, assertFails);
        if (mismatchCount == 0 && pollFailCount == 0 && assertFails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WatchdogNs);
        $display("Watchdog expired before all tests completed");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: tbChecker.sv
`timescale 1ns/100ps

module tbChecker (
    input  logic                           clk,
    input  logic                           ack,
    input  logic                           we,
    input  logic [busPkg::WbAddrWidth-1:0] adr,
    input  logic [busPkg::WbDataWidth-1:0] datR,
    input  logic                           checkEn,
    input  logic [8*12-1:0]                testName,
    input  logic [31:0]                    expValue,
    input  logic [31:0]                    expMask,
    input  logic                           pollFailed,
    output int                             mismatchCount,
    output int                             pollFailCount
);
    int mismatches = 0;
    int pollMisses = 0;

    assign mismatchCount = mismatches;
    assign pollFailCount = pollMisses;

    // read data sits still mid-cycle while ack is high
    always @(negedge clk) begin
        if (ack && !we && checkEn) begin
            if ((datR & expMask) !== (expValue & expMask)) begin
                $display("FAIL %0s (adr %0d): expected %h, actual %h",
                         testName, adr, expValue, datR);
                mismatches++;
            end
        end
        if (pollFailed) begin
            $display("Test %0s: the unit never reported done within the poll limit",
                     testName);
            pollMisses++;
        end
    end

endmodule

// File: decodeCore_assert.sv
`timescale 1ns/100ps

module decodeCoreAssert (
    input logic clk,
    input logic arstN,
    input logic cyc,
    input logic stb,
    input logic ack,
    input logic illegal,
    input logic regWrite
);
    int failCount = 0;

    ackOneCycle: assert property (@(posedge clk) disable iff (!arstN) ack |=> !ack)
        else begin
            $error("ack stayed high for two cycles");
            failCount++;
        end

    // ack only answers a strobe
    ackAfterStrobe: assert property (@(posedge clk) disable iff (!arstN)
            ack |-> $past(cyc && stb))
        else begin
            $error("ack without cyc and stb in the cycle before");
            failCount++;
        end

    illegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
            illegal |-> !regWrite)
        else begin
            $error("illegal result flagged with a register write");
            failCount++;
        end

endmodule

bind decodeCore decodeCoreAssert uAssert (
    .clk     (clk),
    .arstN   (arstN),
    .cyc     (cyc),
    .stb     (stb),
    .ack     (ack),
    .illegal (result.illegal),
    .regWrite(result.regWrite)
);

// File: decodeCore.sv
`timescale 1ns/100ps

module decodeCore (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [busPkg::WbAddrWidth-1:0] adr,
    input  logic [busPkg::WbDataWidth-1:0] datW,
    output logic [busPkg::WbDataWidth-1:0] datR,
    output logic                           ack
);
    import busPkg::*;

    logic    issue;
    logic    outValid;
    logic    done;
    execReqT req;
    execOutT execOut;
    resultT  result;

    wbSlavePort uPort (
        .clk   (clk),
        .arstN (arstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datW  (datW),
        .datR  (datR),
        .ack   (ack),
        .issue (issue),
        .req   (req),
        .result(result),
        .done  (done)
    );

    execUnit uExec (
        .clk     (clk),
        .arstN   (arstN),
        .issue   (issue),
        .req     (req),
        .outValid(outValid),
        .out     (execOut)
    );

    resultBank uResult (
        .clk     (clk),
        .arstN   (arstN),
        .outValid(outValid),
        .out     (execOut),
        .result  (result),
        .done    (done)
    );

endmodule

// File: wbSlavePort.sv
`timescale 1ns/100ps

module wbSlavePort (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           cyc,
    input  logic                           stb,
    input  logic                           we,
    input  logic [busPkg::WbAddrWidth-1:0] adr,
    input  logic [busPkg::WbDataWidth-1:0] datW,
    output logic [busPkg::WbDataWidth-1:0] datR,
    output logic                           ack,
    output logic                           issue,
    output busPkg::execReqT                req,
    input  busPkg::resultT                 result,
    input  logic                           done
);
    import busPkg::*;

    logic                   held;
    logic                   newReq;
    logic [WbDataWidth-1:0] rsQ;
    logic [WbDataWidth-1:0] rtQ;
    logic [WbDataWidth-1:0] pcQ;
    logic [WbDataWidth-1:0] instrQ;
    logic [WbDataWidth-1:0] destWord;

    // one ack per strobe until stb drops
    assign newReq = cyc && stb && !ack && !held;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack   <= 1'b0;
            issue <= 1'b0;
            held  <= 1'b0;
        end else begin
            ack   <= newReq;
            issue <= newReq && we && (adr == AddrInstr);
            if (ack) begin
                held <= 1'b1;
            end else if (!stb) begin
                held <= 1'b0;
            end
        end
    end

    // writes land together with ack
    always_ff @(posedge clk) begin
        if (newReq && we) begin
            case (adr)
                AddrRs:    rsQ <= datW;
                AddrRt:    rtQ <= datW;
                AddrPc:    pcQ <= datW;
                AddrInstr: instrQ <= datW;
                default: ;
            endcase
        end
    end

    assign req = '{instr: instrQ, rsValue: rsQ, rtValue: rtQ, pc: pcQ};

    //////////////////////////////////////////////////
    // read side
    always_comb begin
        destWord = '0;
        destWord[DestIdxLsb +: $bits(result.destReg)] = result.destReg;
        destWord[DestWriteBit] = result.regWrite;
        destWord[DestTakenBit] = result.branchTaken;
        destWord[DestIllegalBit] = result.illegal;
    end

    always_comb begin
        case (adr)
            AddrRs:     datR = rsQ;
            AddrRt:     datR = rtQ;
            AddrPc:     datR = pcQ;
            AddrInstr:  datR = instrQ;
            AddrResult: datR = result.wbValue;
            AddrDest:   datR = destWord;
            AddrNextPc: datR = result.nextPc;
            default:    datR = {{(WbDataWidth-1){1'b0}}, done};
        endcase
    end

endmodule

// File: resultBank.sv
`timescale 1ns/100ps

module resultBank (
    input  logic            clk,
    input  logic            arstN,
    input  logic            outValid,
    input  busPkg::execOutT out,
    output busPkg::resultT  result,
    output logic            done
);
    import isaPkg::*;
    import busPkg::*;

    logic [RegAddrWidth-1:0] destSel;
    logic [DataWidth-1:0]    wbValue;

    always_comb begin
        case (out.regDst)
            dstRt:   destSel = out.rt;
            dstLink: destSel = LinkReg;
            default: destSel = out.rd;
        endcase
    end

    assign wbValue = (out.wbSel == wbLink) ? out.linkValue : out.aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            if (outValid) begin
                result.wbValue     <= wbValue;
                result.destReg     <= destSel;
                result.regWrite    <= out.regWrite;
                result.branchTaken <= out.branchTaken;
                result.illegal     <= out.illegal;
                result.nextPc      <= out.nextPc;
            end
            // a newer instruction in flight keeps done low
            if (out.busy) begin
                done <= 1'b0;
            end else if (outValid) begin
                done <= 1'b1;
            end
        end
    end

endmodule

// File: execUnit.sv
`timescale 1ns/100ps

module execUnit (
    input  logic            clk,
    input  logic            arstN,
    input  logic            issue,
    input  busPkg::execReqT req,
    output logic            outValid,
    output busPkg::execOutT out
);
    import isaPkg::*;
    import busPkg::*;

    ctrlT                 ctrl;
    logic [DataWidth-1:0] rs;
    logic [DataWidth-1:0] immExt;
    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] aluRes;
    logic [DataWidth-1:0] pcPlus4;
    logic [DataWidth-1:0] brOffset;
    logic [DataWidth-1:0] nextPc;
    logic [4:0]           shAmt;
    logic                 taken;
    execOutT              stageD;
    execOutT              stageQ;

    instrDecoder uDecoder (
        .instr(req.instr),
        .ctrl (ctrl)
    );

    assign rs = req.rsValue;

    //////////////////////////////////////////////////
    // operands and ALU
    always_comb begin
        case (ctrl.extOp)
            extSign:  immExt = {{16{req.instr[15]}}, req.instr[15:0]};
            extUpper: immExt = {req.instr[15:0], 16'h0000};
            default:  immExt = {16'h0000, req.instr[15:0]};
        endcase
    end

    assign opB   = (ctrl.srcBSel == srcImm) ? immExt : req.rtValue;
    assign shAmt = (ctrl.srcASel == srcShamt) ? req.instr[10:6] : rs[4:0];

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluRes = rs + opB;
            aluSub:  aluRes = rs - opB;
            aluAnd:  aluRes = rs & opB;
            aluOr:   aluRes = rs | opB;
            aluNor:  aluRes = ~(rs | opB);
            aluXor:  aluRes = rs ^ opB;
            aluSll:  aluRes = opB << shAmt;
            aluSrl:  aluRes = opB >> shAmt;
            aluSra:  aluRes = $signed(opB) >>> shAmt;
            aluSltu: aluRes = {{(DataWidth-1){1'b0}}, rs < opB};
            aluSlt:  aluRes = {{(DataWidth-1){1'b0}}, $signed(rs) < $signed(opB)};
            default: aluRes = opB;
        endcase
    end

    //////////////////////////////////////////////////
    // branch compare and next PC
    always_comb begin
        case (ctrl.branchCond)
            brEq:    taken = (rs == req.rtValue);
            brNe:    taken = (rs != req.rtValue);
            brGtz:   taken = !rs[DataWidth-1] && (rs != '0);
            brLez:   taken = rs[DataWidth-1] || (rs == '0);
            brGez:   taken = !rs[DataWidth-1];
            brLtz:   taken = rs[DataWidth-1];
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4  = req.pc + 32'd4;
    assign brOffset = {{14{req.instr[15]}}, req.instr[15:0], 2'b00};

    always_comb begin
        case (ctrl.pcSrc)
            pcBranch: nextPc = taken ? pcPlus4 + brOffset : pcPlus4;
            pcJump:   nextPc = {pcPlus4[31:28], req.instr[25:0], 2'b00};
            pcReg:    nextPc = rs;
            default:  nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        stageD.aluResult   = aluRes;
        stageD.linkValue   = req.pc + 32'd8;
        stageD.nextPc      = nextPc;
        stageD.regDst      = ctrl.regDst;
        stageD.wbSel       = ctrl.wbSel;
        stageD.regWrite    = ctrl.regWrite;
        stageD.branchTaken = taken;
        stageD.illegal     = ctrl.illegal;
        stageD.rt          = req.instr[20:16];
        stageD.rd          = req.instr[15:11];
        stageD.busy        = 1'b0;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            stageQ <= stageD;
        end
    end

    // busy follows the live issue so done drops right away
    always_comb begin
        out      = stageQ;
        out.busy = issue;
    end

endmodule

// File: instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
    input  logic [31:0]  instr,
    output isaPkg::ctrlT ctrl
);
    import isaPkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    logic [4:0] rtField;

    assign op      = instr[31:26];
    assign funct   = instr[5:0];
    assign rtField = instr[20:16];

    always_comb begin
        ctrl.aluOp      = aluAdd;
        ctrl.srcASel    = srcRs;
        ctrl.srcBSel    = srcRt;
        ctrl.extOp      = extZero;
        ctrl.branchCond = brNone;
        ctrl.pcSrc      = pcSeq;
        ctrl.regDst     = dstRd;
        ctrl.wbSel      = wbAlu;
        ctrl.regWrite   = 1'b0;
        ctrl.illegal    = 1'b0;

        case (op)
            opSpecial: begin
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAdd, fnAddu: ctrl.aluOp = aluAdd;
                    fnSub, fnSubu: ctrl.aluOp = aluSub;
                    fnAnd:         ctrl.aluOp = aluAnd;
                    fnOr:          ctrl.aluOp = aluOr;
                    fnXor:         ctrl.aluOp = aluXor;
                    fnNor:         ctrl.aluOp = aluNor;
                    fnSlt:         ctrl.aluOp = aluSlt;
                    fnSltu:        ctrl.aluOp = aluSltu;
                    fnSllv:        ctrl.aluOp = aluSll;
                    fnSrlv:        ctrl.aluOp = aluSrl;
                    fnSrav:        ctrl.aluOp = aluSra;
                    fnSll, fnSrl, fnSra: begin
                        ctrl.srcASel = srcShamt;
                        ctrl.aluOp = (funct == fnSll) ? aluSll :
                                     (funct == fnSrl) ? aluSrl : aluSra;
                    end
                    fnJr: begin
                        ctrl.pcSrc    = pcReg;
                        ctrl.regWrite = 1'b0;
                    end
                    fnJalr: begin
                        ctrl.pcSrc = pcReg;
                        ctrl.wbSel = wbLink;
                    end
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
                ctrl.regDst   = dstRt;
                ctrl.srcBSel  = srcImm;
                ctrl.regWrite = 1'b1;
                // logical forms keep the zero extension
                case (op)
                    opSlti:  ctrl.aluOp = aluSlt;
                    opSltiu: ctrl.aluOp = aluSltu;
                    opAndi:  ctrl.aluOp = aluAnd;
                    opOri:   ctrl.aluOp = aluOr;
                    opXori:  ctrl.aluOp = aluXor;
                    opLui:   ctrl.aluOp = aluLui;
                    default: ctrl.aluOp = aluAdd;
                endcase
                if (op == opLui) begin
                    ctrl.extOp = extUpper;
                end else if (op inside {opAddi, opAddiu, opSlti, opSltiu}) begin
                    ctrl.extOp = extSign;
                end
            end
            opBeq, opBne, opBgtz, opBlez: begin
                ctrl.pcSrc = pcBranch;
                ctrl.extOp = extSign;
                case (op)
                    opBeq:   ctrl.branchCond = brEq;
                    opBne:   ctrl.branchCond = brNe;
                    opBgtz:  ctrl.branchCond = brGtz;
                    default: ctrl.branchCond = brLez;
                endcase
            end
            opRegImm: begin
                ctrl.pcSrc = pcBranch;
                ctrl.extOp = extSign;
                if (rtField == 5'd1) begin
                    ctrl.branchCond = brGez;
                end else if (rtField == 5'd0) begin
                    ctrl.branchCond = brLtz;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            opJ: ctrl.pcSrc = pcJump;
            opJal: begin
                ctrl.pcSrc    = pcJump;
                ctrl.regDst   = dstLink;
                ctrl.wbSel    = wbLink;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl.illegal = 1'b1;
        endcase

        // illegal falls through as a plain sequential no-op
        if (ctrl.illegal) begin
            ctrl.regWrite   = 1'b0;
            ctrl.pcSrc      = pcSeq;
            ctrl.branchCond = brNone;
        end
    end

endmodule

// File: busPkg.sv
package busPkg;

    localparam int WbDataWidth = 32;
    localparam int WbAddrWidth = 3;

    // register map in word addresses
    localparam logic [WbAddrWidth-1:0] AddrRs     = 3'd0;
    localparam logic [WbAddrWidth-1:0] AddrRt     = 3'd1;
    localparam logic [WbAddrWidth-1:0] AddrPc     = 3'd2;
    localparam logic [WbAddrWidth-1:0] AddrInstr  = 3'd3;
    localparam logic [WbAddrWidth-1:0] AddrResult = 3'd4;
    localparam logic [WbAddrWidth-1:0] AddrDest   = 3'd5;
    localparam logic [WbAddrWidth-1:0] AddrNextPc = 3'd6;
    localparam logic [WbAddrWidth-1:0] AddrStatus = 3'd7;

    // DEST word layout
    localparam int DestIdxLsb     = 0;
    localparam int DestWriteBit   = 8;
    localparam int DestTakenBit   = 9;
    localparam int DestIllegalBit = 10;

    typedef struct packed {
        logic [WbDataWidth-1:0] instr;
        logic [WbDataWidth-1:0] rsValue;
        logic [WbDataWidth-1:0] rtValue;
        logic [WbDataWidth-1:0] pc;
    } execReqT;

    typedef struct packed {
        logic [isaPkg::DataWidth-1:0]    aluResult;
        logic [isaPkg::DataWidth-1:0]    linkValue;
        logic [isaPkg::DataWidth-1:0]    nextPc;
        isaPkg::regDstT                  regDst;
        isaPkg::wbSelT                   wbSel;
        logic                            regWrite;
        logic                            branchTaken;
        logic                            illegal;
        logic [isaPkg::RegAddrWidth-1:0] rt;
        logic [isaPkg::RegAddrWidth-1:0] rd;
        // new instruction entering the stage
        logic                            busy;
    } execOutT;

    typedef struct packed {
        logic [isaPkg::DataWidth-1:0]    wbValue;
        logic [isaPkg::RegAddrWidth-1:0] destReg;
        logic                            regWrite;
        logic                            branchTaken;
        logic                            illegal;
        logic [isaPkg::DataWidth-1:0]    nextPc;
    } resultT;

endpackage

// File: isaPkg.sv
package isaPkg;

    localparam int DataWidth = 32;
    localparam int RegAddrWidth = 5;
    localparam logic [RegAddrWidth-1:0] LinkReg = 5'd31;

    //////////////////////////////////////////////////
    // primary opcodes kept by the core
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opRegImm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddi    = 6'b001000,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111
    } opcodeT;

    // SPECIAL function codes
    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAdd  = 6'b100000,
        fnAddu = 6'b100001,
        fnSub  = 6'b100010,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnNor  = 6'b100111,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } functT;

    //////////////////////////////////////////////////
    // control selectors
    typedef enum logic [3:0] {
        aluAdd  = 4'b0000,
        aluSub  = 4'b0001,
        aluAnd  = 4'b0010,
        aluOr   = 4'b0011,
        aluNor  = 4'b0100,
        aluXor  = 4'b0101,
        aluSll  = 4'b0110,
        aluSrl  = 4'b0111,
        aluSra  = 4'b1000,
        aluSltu = 4'b1001,
        aluSlt  = 4'b1010,
        aluLui  = 4'b1011
    } aluOpT;

    typedef enum logic {srcRs, srcShamt} srcASelT;
    typedef enum logic {srcRt, srcImm} srcBSelT;
    typedef enum logic [1:0] {extZero, extSign, extUpper} extOpT;
    typedef enum logic [2:0] {brNone, brEq, brNe, brGtz, brLez, brGez, brLtz} branchCondT;
    typedef enum logic [1:0] {pcSeq, pcBranch, pcJump, pcReg} pcSrcT;
    typedef enum logic [1:0] {dstRd, dstRt, dstLink} regDstT;
    typedef enum logic {wbAlu, wbLink} wbSelT;

    typedef struct packed {
        aluOpT      aluOp;
        srcASelT    srcASel;
        srcBSelT    srcBSel;
        extOpT      extOp;
        branchCondT branchCond;
        pcSrcT      pcSrc;
        regDstT     regDst;
        wbSelT      wbSel;
        logic       regWrite;
        logic       illegal;
    } ctrlT;

endpackage
